// File: hw/vic20_loader_settings.svh
/*
 * Shared widths, download index codes and fixed load addresses for the
 * download loader. Included by the package and by every RTL module that
 * sizes a port or compares against one of these constants.
 */

`ifndef VIC20_LOADER_SETTINGS_SVH
`define VIC20_LOADER_SETTINGS_SVH

// Bus widths
`define VL_DL_ADDR_W        25
`define VL_MEM_ADDR_W       23
`define VL_DATA_W           8

// Index byte codes sent by the host with each file
`define VL_IDX_ROM          8'h00
`define VL_IDX_PRG_A        8'h01
`define VL_IDX_PRG_B        8'h41
`define VL_IDX_TAP          8'h81

// Fixed placement
`define VL_FIXED_LOAD_ADDR  16'hA000
`define VL_TAP_BASE         23'h20000

// Last sequencer step of the BASIC pointer injection
`define VL_INJECT_LAST_STEP 5'd31

`endif

// File: hw/vic20_loader_pkg.sv
/*
 * Types shared by the loader stages: the download file kind, the two views
 * of a ROM offset, the decoded download byte and the memory write records.
 */

`include "vic20_loader_settings.svh"

package vic20_loader_pkg;

    // File kind selected by the index byte
    typedef enum logic [1:0] {
        KIND_NONE = 2'd0,
        KIND_ROM  = 2'd1,
        KIND_PRG  = 2'd2,
        KIND_TAP  = 2'd3
    } dl_kind_e;

    // Low 16 bits of a download offset, flat or split into 8 KB regions
    typedef union packed {
        logic [15:0] flat;
        struct packed {
            logic [2:0]  region;
            logic [12:0] offset;
        } split;
    } rom_offset_u;

    // One decoded download byte
    typedef struct packed {
        dl_kind_e                  kind;
        logic [`VL_DL_ADDR_W-1:0]  addr;
        logic [`VL_DATA_W-1:0]     data;
        logic [15:0]               rom_addr;
        logic                      rom_valid;
    } dl_byte_t;

    // Final memory write, internal set for on-chip RAM/ROM
    typedef struct packed {
        logic [`VL_MEM_ADDR_W-1:0] addr;
        logic [`VL_DATA_W-1:0]     data;
        logic                      internal;
    } mem_write_t;

    // Untagged write between the address stages and the steer stage
    typedef struct packed {
        logic [`VL_MEM_ADDR_W-1:0] addr;
        logic [`VL_DATA_W-1:0]     data;
    } stream_write_t;

endpackage

// File: hw/dl_stream_decode.sv
/*
 * Combinational front end of the loader. Classifies each download byte by
 * the index code and remaps system ROM offsets into their memory windows.
 */

`timescale 1ns/1ns

`include "vic20_loader_settings.svh"

module dl_stream_decode (
    input  logic                        dl_active_i,
    input  logic [7:0]                  dl_index_i,
    input  logic                        dl_wr_i,
    input  logic [`VL_DL_ADDR_W-1:0]    dl_addr_i,
    input  logic [`VL_DATA_W-1:0]       dl_data_i,
    output logic                        byte_wr_o,
    output vic20_loader_pkg::dl_byte_t  byte_o,
    output logic                        prg_active_o
);
    import vic20_loader_pkg::*;

    dl_kind_e    kind;
    rom_offset_u rom_off;
    logic [15:0] rom_addr;
    logic        rom_valid;

    // File kind only exists while the host holds a download open
    always_comb begin
        kind = KIND_NONE;
        if (dl_active_i) begin
            case (dl_index_i)
                `VL_IDX_ROM:                 kind = KIND_ROM;
                `VL_IDX_PRG_A, `VL_IDX_PRG_B: kind = KIND_PRG;
                `VL_IDX_TAP:                 kind = KIND_TAP;
                default:                     kind = KIND_NONE;
            endcase
        end
    end

    assign rom_off.flat = dl_addr_i[15:0];

    // ROM image layout, 8 KB per region. Regions 0 and 1 held the drive ROM
    always_comb begin
        rom_addr  = rom_off.flat;
        rom_valid = 1'b0;
        if (kind == KIND_ROM) begin
            rom_valid = 1'b1;
            case (rom_off.split.region)
                3'b010, 3'b011: rom_addr = {3'b111, rom_off.split.offset};
                3'b100:         rom_addr = {3'b110, rom_off.split.offset};
                3'b101:         rom_addr = {4'b1000, rom_off.split.offset[11:0]};
                default:        rom_valid = 1'b0;
            endcase
        end
    end

    assign byte_wr_o    = dl_wr_i;
    assign prg_active_o = (kind == KIND_PRG);
    assign byte_o       = '{kind: kind, addr: dl_addr_i, data: dl_data_i,
                            rom_addr: rom_addr, rom_valid: rom_valid};

endmodule

// File: hw/load_address_tracker.sv
/*
 * Turns decoded download bytes into addressed stream writes, one cycle
 * after the strobe. Parses the program header, keeps the last program data
 * address and flags programs that land on the cartridge address.
 */

`timescale 1ns/1ns

`include "vic20_loader_settings.svh"

module load_address_tracker (
    input  logic                            clk_sys,
    input  logic                            rst_i,
    input  logic                            byte_wr_i,
    input  vic20_loader_pkg::dl_byte_t      byte_i,
    input  logic                            load_fixed_i,
    output logic                            st_wr_o,
    output vic20_loader_pkg::stream_write_t st_data_o,
    output vic20_loader_pkg::dl_kind_e      st_kind_o,
    output logic [15:0]                     end_addr_o,
    output logic                            auto_reset_o
);
    import vic20_loader_pkg::*;

    logic [15:0]               load_addr_q;
    logic [15:0]               prg_offset;
    logic [15:0]               prg_addr;
    logic                      prg_header;
    logic                      prg_data_wr;
    logic                      wr_en;
    logic [`VL_MEM_ADDR_W-1:0] wr_addr;

    // First two bytes carry the load address unless fixed mode is on
    assign prg_offset  = byte_i.addr[15:0];
    assign prg_header  = !load_fixed_i && (byte_i.addr[`VL_DL_ADDR_W-1:1] == '0);
    assign prg_addr    = load_fixed_i ? `VL_FIXED_LOAD_ADDR + prg_offset
                                      : load_addr_q + prg_offset - 16'd2;
    assign prg_data_wr = byte_wr_i && (byte_i.kind == KIND_PRG) && !prg_header;

    always_comb begin
        wr_en   = 1'b0;
        wr_addr = '0;
        case (byte_i.kind)
            KIND_PRG: begin
                wr_en   = !prg_header;
                wr_addr = `VL_MEM_ADDR_W'(prg_addr);
            end
            KIND_TAP: begin
                wr_en   = 1'b1;
                wr_addr = `VL_TAP_BASE + byte_i.addr[`VL_MEM_ADDR_W-1:0];
            end
            KIND_ROM: begin
                wr_en   = byte_i.rom_valid;
                wr_addr = `VL_MEM_ADDR_W'(byte_i.rom_addr);
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            st_wr_o      <= 1'b0;
            auto_reset_o <= 1'b0;
        end else begin
            st_wr_o <= byte_wr_i && wr_en;
            // Offset 0 marks a new program, a write at $A000 sets the flag again
            if (byte_wr_i && byte_i.kind == KIND_PRG && byte_i.addr == '0)
                auto_reset_o <= 1'b0;
            if (prg_data_wr && prg_addr == `VL_FIXED_LOAD_ADDR)
                auto_reset_o <= 1'b1;
        end
    end

    // Payload and header capture
    always_ff @(posedge clk_sys) begin
        if (byte_wr_i) begin
            st_data_o.addr <= wr_addr;
            st_data_o.data <= byte_i.data;
            st_kind_o      <= byte_i.kind;
        end
        if (byte_wr_i && byte_i.kind == KIND_PRG && prg_header) begin
            if (byte_i.addr[0])
                load_addr_q[15:8] <= byte_i.data;
            else
                load_addr_q[7:0]  <= byte_i.data;
        end
        if (prg_data_wr)
            end_addr_o <= prg_addr;
    end

endmodule

// File: hw/basic_pointer_injector.sv
/*
 * After a program download ends, writes its end address into the eight
 * BASIC pointer bytes, one write every other cycle, then raises a one-cycle
 * reset request if the program was loaded at the cartridge address.
 */

`timescale 1ns/1ns

`include "vic20_loader_settings.svh"

module basic_pointer_injector (
    input  logic                            clk_sys,
    input  logic                            rst_i,
    input  logic                            prg_active_i,
    input  logic [15:0]                     end_addr_i,
    input  logic                            auto_reset_i,
    output logic                            inj_wr_o,
    output vic20_loader_pkg::stream_write_t inj_data_o,
    output logic                            force_reset_o
);

    logic [4:0] step_q;
    logic       prg_active_q;
    logic       arm_q;
    logic [7:0] ptr_addr;

    // ========================================================================
    // Step sequencer
    // ========================================================================

    // Runs 1..31 once per program download, wraps back to idle at 0
    always_ff @(posedge clk_sys) begin
        if (rst_i) begin
            step_q       <= 5'd0;
            prg_active_q <= 1'b0;
            arm_q        <= 1'b0;
        end else begin
            prg_active_q <= prg_active_i;
            if (prg_active_q && !prg_active_i) begin
                step_q <= 5'd1;
                arm_q  <= auto_reset_i;
            end else if (step_q != 5'd0) begin
                step_q <= step_q + 5'd1;
            end
            if (step_q == `VL_INJECT_LAST_STEP)
                arm_q <= 1'b0;
        end
    end

    // ========================================================================
    // Pointer writes
    // ========================================================================

    // Text end, variables start, arrays start, arrays end, then load end
    always_comb begin
        case (step_q[3:1])
            3'd0:    ptr_addr = 8'h2D;
            3'd1:    ptr_addr = 8'h2E;
            3'd2:    ptr_addr = 8'h2F;
            3'd3:    ptr_addr = 8'h30;
            3'd4:    ptr_addr = 8'h31;
            3'd5:    ptr_addr = 8'h32;
            3'd6:    ptr_addr = 8'hAE;
            default: ptr_addr = 8'hAF;
        endcase
    end

    // Odd steps 1 to 15 only
    assign inj_wr_o        = step_q[0] && !step_q[4];
    assign inj_data_o.addr = `VL_MEM_ADDR_W'(ptr_addr);
    assign inj_data_o.data = step_q[1] ? end_addr_i[15:8] : end_addr_i[7:0];
    assign force_reset_o   = arm_q && (step_q == `VL_INJECT_LAST_STEP);

    // The host has no back-pressure, next download must wait for the sequence
    a_no_download_during_inject: assert property (
        @(posedge clk_sys) disable iff (rst_i)
        (step_q != 5'd0) |-> !$rose(prg_active_i)
    );

endmodule

// File: hw/mem_write_steer.sv
/*
 * Final loader stage. Merges the stream writes and the injected pointer
 * writes, tags each as internal or external memory and registers the result.
 */

`timescale 1ns/1ns

`include "vic20_loader_settings.svh"

module mem_write_steer (
    input  logic                            clk_sys,
    input  logic                            rst_i,
    input  logic                            st_wr_i,
    input  vic20_loader_pkg::stream_write_t st_data_i,
    input  logic                            inj_wr_i,
    input  vic20_loader_pkg::stream_write_t inj_data_i,
    input  vic20_loader_pkg::dl_kind_e      kind_i,
    output logic                            mem_wr_o,
    output vic20_loader_pkg::mem_write_t    mem_wr_data_o
);
    import vic20_loader_pkg::*;

    stream_write_t sel;
    logic          prg_internal;
    logic          internal;

    assign sel = inj_wr_i ? inj_data_i : st_data_i;

    // Low RAM, 4 KB main RAM block and colour RAM live on chip
    assign prg_internal = (st_data_i.addr[`VL_MEM_ADDR_W-1:16] == '0) &&
                          (st_data_i.addr[15:10] == 6'b000000 ||
                           st_data_i.addr[15:12] == 4'b0001 ||
                           st_data_i.addr[15:10] == 6'b100101);

    always_comb begin
        internal = 1'b0;
        if (inj_wr_i) begin
            internal = 1'b1;
        end else begin
            case (kind_i)
                KIND_ROM: internal = 1'b1;
                KIND_PRG: internal = prg_internal;
                default:  internal = 1'b0;
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst_i)
            mem_wr_o <= 1'b0;
        else
            mem_wr_o <= st_wr_i || inj_wr_i;
    end

    always_ff @(posedge clk_sys) begin
        if (st_wr_i || inj_wr_i)
            mem_wr_data_o <= '{addr: sel.addr, data: sel.data, internal: internal};
    end

    // Injection starts only after the program stream has drained
    a_no_write_collision: assert property (
        @(posedge clk_sys) disable iff (rst_i)
        !(st_wr_i && inj_wr_i)
    );

endmodule

// File: hw/vic20_loader.sv
/*
 * Download loader top. Connects the byte decoder, the address tracker, the
 * BASIC pointer injector and the write steer stage. A stream byte reaches
 * mem_wr_o two cycles after its dl_wr_i strobe.
 */

`timescale 1ns/1ns

`include "vic20_loader_settings.svh"

module vic20_loader (
    input  logic                         clk_sys,
    input  logic                         rst_i,
    input  logic                         dl_active_i,
    input  logic [7:0]                   dl_index_i,
    input  logic                         dl_wr_i,
    input  logic [`VL_DL_ADDR_W-1:0]     dl_addr_i,
    input  logic [`VL_DATA_W-1:0]        dl_data_i,
    input  logic                         load_fixed_i,
    output logic                         mem_wr_o,
    output vic20_loader_pkg::mem_write_t mem_wr_data_o,
    output logic                         force_reset_o
);
    import vic20_loader_pkg::*;

    logic          byte_wr;
    dl_byte_t      dl_byte;
    logic          prg_active;
    logic          st_wr;
    stream_write_t st_data;
    dl_kind_e      st_kind;
    logic [15:0]   end_addr;
    logic          auto_reset;
    logic          inj_wr;
    stream_write_t inj_data;

    dl_stream_decode dl_stream_decode_inst (
        .dl_active_i  (dl_active_i),
        .dl_index_i   (dl_index_i),
        .dl_wr_i      (dl_wr_i),
        .dl_addr_i    (dl_addr_i),
        .dl_data_i    (dl_data_i),
        .byte_wr_o    (byte_wr),
        .byte_o       (dl_byte),
        .prg_active_o (prg_active)
    );

    load_address_tracker load_address_tracker_inst (
        .clk_sys      (clk_sys),
        .rst_i        (rst_i),
        .byte_wr_i    (byte_wr),
        .byte_i       (dl_byte),
        .load_fixed_i (load_fixed_i),
        .st_wr_o      (st_wr),
        .st_data_o    (st_data),
        .st_kind_o    (st_kind),
        .end_addr_o   (end_addr),
        .auto_reset_o (auto_reset)
    );

    basic_pointer_injector basic_pointer_injector_inst (
        .clk_sys       (clk_sys),
        .rst_i         (rst_i),
        .prg_active_i  (prg_active),
        .end_addr_i    (end_addr),
        .auto_reset_i  (auto_reset),
        .inj_wr_o      (inj_wr),
        .inj_data_o    (inj_data),
        .force_reset_o (force_reset_o)
    );

    mem_write_steer mem_write_steer_inst (
        .clk_sys       (clk_sys),
        .rst_i         (rst_i),
        .st_wr_i       (st_wr),
        .st_data_i     (st_data),
        .inj_wr_i      (inj_wr),
        .inj_data_i    (inj_data),
        .kind_i        (st_kind),
        .mem_wr_o      (mem_wr_o),
        .mem_wr_data_o (mem_wr_data_o)
    );

endmodule

// File: verification/tb_vic20_loader.sv
/*
 * Testbench for the download loader. Streams a ROM image, three program
 * files and a tape image into the DUT, predicts each memory write with a
 * reference function and checks address, data, tag, latency and reset pulse.
 */

`timescale 1ns/1ns

`include "vic20_loader_settings.svh"

module tb_vic20_loader;
    import vic20_loader_pkg::*;

    // Stimulus is about 300 cycles, so this only trips on a hang
    localparam int unsigned TIMEOUT_CYCLES = 4000;
    localparam logic [7:0] PTR_ADDR [8] = '{8'h2D, 8'h2E, 8'h2F, 8'h30,
                                           8'h31, 8'h32, 8'hAE, 8'hAF};

    typedef struct packed {
        logic       valid;
        mem_write_t w;
    } ref_result_t;

    typedef struct packed {
        mem_write_t  w;
        int unsigned cyc;
    } exp_write_t;

    logic                     clk_sys;
    logic                     rst_i;
    logic                     dl_active_i;
    logic [7:0]               dl_index_i;
    logic                     dl_wr_i;
    logic [`VL_DL_ADDR_W-1:0] dl_addr_i;
    logic [`VL_DATA_W-1:0]    dl_data_i;
    logic                     load_fixed_i;
    logic                     mem_wr_o;
    mem_write_t               mem_wr_data_o;
    logic                     force_reset_o;

    exp_write_t  exp_q[$];
    int unsigned cycle;
    int unsigned reset_pulses;
    int unsigned reset_cycle;
    integer      seed;
    logic [15:0] last_prg_addr;

    vic20_loader vic20_loader_inst (
        .clk_sys       (clk_sys),
        .rst_i         (rst_i),
        .dl_active_i   (dl_active_i),
        .dl_index_i    (dl_index_i),
        .dl_wr_i       (dl_wr_i),
        .dl_addr_i     (dl_addr_i),
        .dl_data_i     (dl_data_i),
        .load_fixed_i  (load_fixed_i),
        .mem_wr_o      (mem_wr_o),
        .mem_wr_data_o (mem_wr_data_o),
        .force_reset_o (force_reset_o)
    );

    always #20 clk_sys = ~clk_sys;

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] got_val);
        stop_with_failure($sformatf("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h",
                                    $time, name, exp_val, got_val));
    endtask

    // ========================================================================
    // Reference model
    // ========================================================================

    function automatic ref_result_t expected_write(input logic [7:0] index,
            input logic [`VL_DL_ADDR_W-1:0] offset, input logic [7:0] data,
            input logic fixed, input logic [15:0] load_addr);
        ref_result_t r;
        logic [15:0] a16;
        r        = '0;
        r.w.data = data;
        r.valid  = 1'b1;
        case (index)
            `VL_IDX_ROM: begin
                r.w.internal = 1'b1;
                if (offset[15:0] >= 16'h4000 && offset[15:0] < 16'h8000)
                    r.w.addr = 23'hE000 + 23'(offset[12:0]);
                else if (offset[15:0] >= 16'h8000 && offset[15:0] < 16'hA000)
                    r.w.addr = 23'hC000 + 23'(offset[12:0]);
                else if (offset[15:0] >= 16'hA000 && offset[15:0] < 16'hC000)
                    r.w.addr = 23'h8000 + 23'(offset[11:0]);
                else
                    r.valid = 1'b0;
            end
            `VL_IDX_PRG_A, `VL_IDX_PRG_B: begin
                a16 = fixed ? 16'hA000 + offset[15:0] : load_addr + offset[15:0] - 16'd2;
                // Header bytes only carry the load address
                r.valid      = fixed || offset >= 2;
                r.w.addr     = 23'(a16);
                r.w.internal = a16 < 16'h0400 || (a16 >= 16'h1000 && a16 < 16'h2000) ||
                               (a16 >= 16'h9400 && a16 < 16'h9800);
            end
            default: begin
                r.w.addr     = 23'h20000 + offset[22:0];
                r.w.internal = 1'b0;
            end
        endcase
        return r;
    endfunction

    // ========================================================================
    // Stimulus
    // ========================================================================

    task automatic expect_write(input mem_write_t w, input int unsigned cyc);
        exp_write_t e;
        e.w   = w;
        e.cyc = cyc;
        exp_q.push_back(e);
    endtask

    task automatic idle_cycles(input int unsigned n);
        repeat (n) begin
            @(posedge clk_sys);
            #2;
            dl_wr_i = 1'b0;
        end
    endtask

    // Drives one strobed byte and queues its write for two cycles later
    task automatic send_byte(input logic [`VL_DL_ADDR_W-1:0] offset,
                             input logic [7:0] data, input logic [15:0] load_addr,
                             output ref_result_t r);
        @(posedge clk_sys);
        #2;
        dl_wr_i   = 1'b1;
        dl_addr_i = offset;
        dl_data_i = data;
        r = expected_write(dl_index_i, offset, data, load_fixed_i, load_addr);
        if (r.valid)
            expect_write(r.w, cycle + 2);
    endtask

    task automatic open_download(input logic [7:0] index, input logic fixed);
        @(posedge clk_sys);
        #2;
        dl_index_i   = index;
        load_fixed_i = fixed;
        dl_active_i  = 1'b1;
    endtask

    task automatic close_download();
        idle_cycles(2);
        @(posedge clk_sys);
        #2;
        dl_active_i = 1'b0;
    endtask

    task automatic run_rom_image();
        ref_result_t r;
        logic [15:0] off;
        int unsigned i;
        open_download(`VL_IDX_ROM, 1'b0);
        // Start, middle and end of each 8 KB region
        for (i = 0; i < 6; i++) begin
            off = 16'(i) << 13;
            send_byte(25'(off), 8'($random(seed)), 16'h0, r);
            send_byte(25'(off + 16'h0FFF), 8'($random(seed)), 16'h0, r);
            send_byte(25'(off + 16'h1FFF), 8'($random(seed)), 16'h0, r);
        end
        for (i = 0; i < 10; i++) begin
            off = 16'(($random(seed) & 32'hFFFF) % 32'hC000);
            send_byte(25'(off), 8'($random(seed)), 16'h0, r);
        end
        close_download();
    endtask

    task automatic run_program(input logic [7:0] index, input logic fixed,
                               input logic [15:0] hdr_addr, input int unsigned n_data,
                               input int unsigned exp_pulses);
        ref_result_t r;
        int unsigned k;
        int unsigned first;
        int unsigned c;
        int unsigned pulses_before;
        mem_write_t  w;
        open_download(index, fixed);
        first = fixed ? 0 : 2;
        if (!fixed) begin
            send_byte(25'd0, hdr_addr[7:0], hdr_addr, r);
            send_byte(25'd1, hdr_addr[15:8], hdr_addr, r);
        end
        for (k = first; k < first + n_data; k++) begin
            send_byte(25'(k), 8'($random(seed)), hdr_addr, r);
            last_prg_addr = r.w.addr[15:0];
        end
        close_download();
        c             = cycle;
        pulses_before = reset_pulses;
        // Eight pointer writes on odd steps with the low byte first
        for (k = 0; k < 8; k++) begin
            w.addr     = 23'(PTR_ADDR[3'(k)]);
            w.data     = k[0] ? last_prg_addr[15:8] : last_prg_addr[7:0];
            w.internal = 1'b1;
            expect_write(w, c + 2 + 2 * k);
        end
        idle_cycles(40);
        assert (reset_pulses - pulses_before == exp_pulses)
            else report_mismatch("force_reset_o pulse count", exp_pulses,
                                 reset_pulses - pulses_before);
        if (exp_pulses != 0) begin
            assert (reset_cycle == c + 31)
                else report_mismatch("force_reset_o cycle", c + 31, reset_cycle);
        end
    endtask

    task automatic run_tape_image(input int unsigned n_bytes);
        ref_result_t r;
        int unsigned k;
        open_download(`VL_IDX_TAP, 1'b0);
        for (k = 0; k < n_bytes; k++)
            send_byte(25'(k), 8'($random(seed)), 16'h0, r);
        close_download();
    endtask

    // ========================================================================
    // Checking
    // ========================================================================

    always @(posedge clk_sys) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
            stop_with_failure("Timeout: the loader did not finish within the cycle limit");
    end

    always @(negedge clk_sys) begin
        if (!rst_i && force_reset_o) begin
            reset_pulses <= reset_pulses + 1;
            reset_cycle  <= cycle;
        end
    end

    always @(negedge clk_sys) begin : compare_writes
        exp_write_t e;
        if (!rst_i && mem_wr_o) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("A memory write appeared when none was expected");
            end else begin
                e = exp_q.pop_front();
                assert (cycle == e.cyc)
                    else report_mismatch("mem_wr_o cycle", e.cyc, cycle);
                assert (mem_wr_data_o.addr == e.w.addr)
                    else report_mismatch("mem_wr_data_o.addr", 32'(e.w.addr),
                                         32'(mem_wr_data_o.addr));
                assert (mem_wr_data_o.data == e.w.data)
                    else report_mismatch("mem_wr_data_o.data", 32'(e.w.data),
                                         32'(mem_wr_data_o.data));
                assert (mem_wr_data_o.internal == e.w.internal)
                    else report_mismatch("mem_wr_data_o.internal", 32'(e.w.internal),
                                         32'(mem_wr_data_o.internal));
            end
        end
    end

    initial begin
        clk_sys       = 1'b0;
        rst_i         = 1'b1;
        dl_active_i   = 1'b0;
        dl_index_i    = 8'h00;
        dl_wr_i       = 1'b0;
        dl_addr_i     = '0;
        dl_data_i     = '0;
        load_fixed_i  = 1'b0;
        cycle         = 0;
        reset_pulses  = 0;
        reset_cycle   = 0;
        seed          = 44;
        last_prg_addr = 16'h0;
        repeat (8) @(posedge clk_sys);
        #2;
        rst_i = 1'b0;
        assert (mem_wr_o == 1'b0 && force_reset_o == 1'b0)
            else stop_with_failure("Outputs were not idle after reset");

        run_rom_image();
        run_program(`VL_IDX_PRG_A, 1'b0, 16'h1001, 20, 0);
        run_program(`VL_IDX_PRG_B, 1'b0, 16'h2000, 16, 0);
        run_program(`VL_IDX_PRG_A, 1'b1, 16'h0000, 12, 1);
        run_tape_image(16);

        // Every write falls due two cycles after its strobe, so none may be left
        idle_cycles(4);
        if (exp_q.size() != 0 || reset_pulses != 1) begin
            stop_with_failure("Writes still pending or wrong reset request count at end");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

// File: flist.f
+incdir+hw
hw/vic20_loader_pkg.sv
hw/dl_stream_decode.sv
hw/load_address_tracker.sv
hw/basic_pointer_injector.sv
hw/mem_write_steer.sv
hw/vic20_loader.sv
verification/tb_vic20_loader.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the loader testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_vic20_loader \
    -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || echo "Build or simulation returned an error status" >> sim.log

cat build.log sim.log

if [ ! -s sim.log ] || grep -q "TESTBENCH FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi

echo "Simulation passed"
exit 0
